// File: flist.f
hw/uart_frame_pkg.sv
hw/axil_pkg.sv
hw/uart_byte_tx.sv
hw/uart_byte_rx.sv
hw/frame_tx_engine.sv
hw/frame_rx_engine.sv
hw/frame_ctrl_regs.sv
hw/uart_frame_top.sv
testbench/tb_uart_frame.sv

// File: hw/axil_pkg.sv
/*
 * AXI4-Lite request and response structs
 * register offsets of the frame link
 */
package axil_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef struct packed {
		logic [ADDR_W-1:0]   awaddr;
		logic                awvalid;
		logic [DATA_W-1:0]   wdata;
		logic [DATA_W/8-1:0] wstrb;
		logic                wvalid;
		logic                bready;
		logic [ADDR_W-1:0]   araddr;
		logic                arvalid;
		logic                rready;
	} axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		logic [1:0]        bresp;
		logic              arready;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		logic [1:0]        rresp;
	} axil_rsp_t;

	typedef enum logic [ADDR_W-1:0] {
		CTRL    = 8'h00,
		STATUS  = 8'h04,
		TX_BUF0 = 8'h10,
		TX_BUF1 = 8'h14,
		TX_BUF2 = 8'h18,
		TX_BUF3 = 8'h1c,
		RX_BUF0 = 8'h20,
		RX_BUF1 = 8'h24,
		RX_BUF2 = 8'h28,
		RX_BUF3 = 8'h2c
	} reg_addr_e;

endpackage

// File: hw/frame_ctrl_regs.sv
`timescale 1ns/1ps
/*
 * AXI4-Lite register slave of the frame link
 * CTRL and STATUS registers, transmit and receive buffers
 */
module frame_ctrl_regs (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  axil_pkg::axil_req_t        axil_req,
	output axil_pkg::axil_rsp_t        axil_rsp,
	input  logic                       tx_busy,
	output uart_frame_pkg::tx_cmd_t    tx_cmd,
	output uart_frame_pkg::payload_t   tx_payload,
	input  uart_frame_pkg::rx_wr_t     rx_wr,
	input  uart_frame_pkg::rx_result_t rx_result
);

	logic aw_fire;
	logic ar_fire;
	logic tx_wr;
	logic bvalid_q;
	logic rvalid_q;
	logic [axil_pkg::DATA_W-1:0] rdata_q;
	logic [axil_pkg::DATA_W-1:0] rd_mux;
	logic [axil_pkg::DATA_W-1:0] status_word;
	logic [uart_frame_pkg::LEN_W-1:0] ctrl_len;
	logic [uart_frame_pkg::LEN_W-1:0] wr_len;
	logic [uart_frame_pkg::LEN_W-1:0] clip_len;
	logic [uart_frame_pkg::LEN_W-1:0] rx_len;
	logic rx_valid;
	logic overflow;
	uart_frame_pkg::payload_t tx_buf;
	uart_frame_pkg::payload_t rx_buf;

	// address and data taken together, one write outstanding
	assign aw_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
	assign ar_fire = axil_req.arvalid && !rvalid_q;
	assign tx_wr = aw_fire && (axil_req.awaddr inside {axil_pkg::TX_BUF0, axil_pkg::TX_BUF1,
		axil_pkg::TX_BUF2, axil_pkg::TX_BUF3});

	always_comb begin
		axil_rsp.awready = aw_fire;
		axil_rsp.wready  = aw_fire;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = 2'b00;
		axil_rsp.arready = !rvalid_q;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = 2'b00;
	end

	// length of this CTRL write, at most a full payload
	assign wr_len = axil_req.wstrb[0] ? axil_req.wdata[uart_frame_pkg::LEN_W-1:0] : ctrl_len;
	assign clip_len = (wr_len > uart_frame_pkg::LEN_MAX) ? uart_frame_pkg::LEN_MAX : wr_len;
	assign tx_payload = tx_buf;
	assign status_word = {19'b0, rx_len, 5'b0, overflow, rx_valid, tx_busy};

	always_comb begin
		rd_mux = '0;
		case (axil_req.araddr)
			axil_pkg::CTRL: rd_mux = {{(axil_pkg::DATA_W - uart_frame_pkg::LEN_W){1'b0}}, ctrl_len};
			axil_pkg::STATUS: rd_mux = status_word;
			axil_pkg::TX_BUF0, axil_pkg::TX_BUF1, axil_pkg::TX_BUF2, axil_pkg::TX_BUF3:
				rd_mux = tx_buf[{axil_req.araddr[3:2], 2'b00} +: 4];
			axil_pkg::RX_BUF0, axil_pkg::RX_BUF1, axil_pkg::RX_BUF2, axil_pkg::RX_BUF3:
				rd_mux = rx_buf[{axil_req.araddr[3:2], 2'b00} +: 4];
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			rdata_q  <= '0;
			ctrl_len <= '0;
			tx_cmd   <= '0;
			rx_valid <= 1'b0;
			overflow <= 1'b0;
			rx_len   <= '0;
		end else begin
			tx_cmd.start <= 1'b0;
			if (aw_fire)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;
			if (ar_fire) begin
				rvalid_q <= 1'b1;
				rdata_q  <= rd_mux;
			end else if (axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
			if (aw_fire && axil_req.awaddr == axil_pkg::CTRL) begin
				if (axil_req.wstrb[0])
					ctrl_len <= clip_len;
				// start while a frame is going out is dropped
				if (axil_req.wstrb[1] && axil_req.wdata[8] && clip_len != '0 && !tx_busy) begin
					tx_cmd.start  <= 1'b1;
					tx_cmd.length <= clip_len;
				end
			end
			if (rx_result.done) begin
				rx_valid <= 1'b1;
				overflow <= rx_result.overflow;
				rx_len   <= rx_result.length;
			end else if (aw_fire && axil_req.awaddr == axil_pkg::STATUS &&
				axil_req.wstrb[0] && axil_req.wdata[1]) begin
				rx_valid <= 1'b0;
				overflow <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (tx_wr && axil_req.wstrb[b])
				tx_buf[{axil_req.awaddr[3:2], 2'(b)}] <= axil_req.wdata[8*b +: 8];
		end
	end

	// each new frame overwrites from byte 0
	always_ff @(posedge sys_clk) begin
		if (rx_wr.en)
			rx_buf[rx_wr.idx] <= rx_wr.data;
	end

endmodule

// File: hw/frame_rx_engine.sv
`timescale 1ns/1ps
/*
 * frame receive parser
 * finds {{ ... }}, writes the payload out, flags overflow
 * drops a partial frame after a silence timeout
 */
module frame_rx_engine (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::byte_req_t  rx_byte,
	output uart_frame_pkg::rx_wr_t     wr,
	output uart_frame_pkg::rx_result_t result
);

	uart_frame_pkg::rx_state_e state;
	logic [uart_frame_pkg::LEN_W-1:0] cnt;
	logic [uart_frame_pkg::TMO_CNT_W-1:0] idle_cnt;
	logic ovf;
	logic pend_valid;
	logic [7:0] pend_data;
	logic take_en;
	logic [7:0] take_data;
	logic is_open;
	logic is_close;

	assign is_open = rx_byte.valid && rx_byte.data == uart_frame_pkg::OPEN_CHAR;
	assign is_close = rx_byte.valid && rx_byte.data == uart_frame_pkg::CLOSE_CHAR;

	// lone } is content, written first, the byte after it one cycle later
	always_comb begin
		take_en = 1'b0;
		take_data = rx_byte.data;
		if (pend_valid) begin
			take_en = 1'b1;
			take_data = pend_data;
		end else if (rx_byte.valid && !is_close) begin
			if (state == uart_frame_pkg::RX_BODY) begin
				take_en = 1'b1;
			end else if (state == uart_frame_pkg::RX_CLOSE1) begin
				take_en = 1'b1;
				take_data = uart_frame_pkg::CLOSE_CHAR;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= uart_frame_pkg::RX_IDLE;
			cnt        <= '0;
			idle_cnt   <= '0;
			ovf        <= 1'b0;
			pend_valid <= 1'b0;
			pend_data  <= '0;
			wr         <= '0;
			result     <= '0;
		end else begin
			wr.en   <= take_en && (cnt != uart_frame_pkg::LEN_MAX);
			wr.idx  <= cnt[3:0];
			wr.data <= take_data;
			pend_valid <= (state == uart_frame_pkg::RX_CLOSE1) && rx_byte.valid && !is_close;
			pend_data  <= rx_byte.data;
			result.done     <= (state == uart_frame_pkg::RX_CLOSE1) && is_close;
			result.length   <= cnt;
			result.overflow <= ovf;
			// bytes past a full buffer are dropped
			if (take_en) begin
				if (cnt != uart_frame_pkg::LEN_MAX)
					cnt <= cnt + 1'b1;
				else
					ovf <= 1'b1;
			end
			if (state == uart_frame_pkg::RX_IDLE || rx_byte.valid)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1;
			if (rx_byte.valid) begin
				case (state)
					uart_frame_pkg::RX_IDLE: begin
						if (is_open)
							state <= uart_frame_pkg::RX_OPEN1;
					end
					uart_frame_pkg::RX_OPEN1: begin
						state <= is_open ? uart_frame_pkg::RX_BODY : uart_frame_pkg::RX_IDLE;
						cnt   <= '0;
						ovf   <= 1'b0;
					end
					uart_frame_pkg::RX_BODY: begin
						if (is_close)
							state <= uart_frame_pkg::RX_CLOSE1;
					end
					default: state <= is_close ? uart_frame_pkg::RX_IDLE : uart_frame_pkg::RX_BODY;
				endcase
			end else if (state != uart_frame_pkg::RX_IDLE && idle_cnt == uart_frame_pkg::TMO_LAST) begin
				state <= uart_frame_pkg::RX_IDLE;
			end
		end
	end

endmodule

// File: hw/frame_tx_engine.sv
`timescale 1ns/1ps
/*
 * frame transmit sequencer
 * sends {{ payload }} through the byte serializer
 */
module frame_tx_engine (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  uart_frame_pkg::tx_cmd_t   cmd,
	input  uart_frame_pkg::payload_t  payload,
	input  logic                      byte_done,
	output uart_frame_pkg::byte_req_t byte_req,
	output logic                      busy
);

	uart_frame_pkg::tx_state_e state;
	uart_frame_pkg::tx_state_e nxt_state;
	uart_frame_pkg::payload_t payload_q;
	logic [uart_frame_pkg::LEN_W-1:0] len_q;
	logic [3:0] idx;
	logic [3:0] nxt_idx;
	logic kick;
	logic last_body;

	assign busy = (state != uart_frame_pkg::TX_IDLE);
	assign last_body = ({1'b0, idx} == len_q - 1'b1);

	// state is the byte on the line, nxt_state the one requested on done
	always_comb begin
		nxt_state = state;
		nxt_idx = idx;
		if (byte_done) begin
			case (state)
				uart_frame_pkg::TX_OPEN1: nxt_state = uart_frame_pkg::TX_OPEN2;
				uart_frame_pkg::TX_OPEN2: begin
					nxt_state = uart_frame_pkg::TX_BODY;
					nxt_idx = '0;
				end
				uart_frame_pkg::TX_BODY: begin
					if (last_body)
						nxt_state = uart_frame_pkg::TX_CLOSE1;
					else
						nxt_idx = idx + 1'b1;
				end
				uart_frame_pkg::TX_CLOSE1: nxt_state = uart_frame_pkg::TX_CLOSE2;
				default: nxt_state = uart_frame_pkg::TX_IDLE;
			endcase
		end
		// next byte goes out in the cycle done arrives
		byte_req.valid = kick || (byte_done && nxt_state != uart_frame_pkg::TX_IDLE);
		case (nxt_state)
			uart_frame_pkg::TX_BODY: byte_req.data = payload_q[nxt_idx];
			uart_frame_pkg::TX_CLOSE1, uart_frame_pkg::TX_CLOSE2: byte_req.data = uart_frame_pkg::CLOSE_CHAR;
			default: byte_req.data = uart_frame_pkg::OPEN_CHAR;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_frame_pkg::TX_IDLE;
			idx   <= '0;
			len_q <= '0;
			kick  <= 1'b0;
		end else begin
			kick <= 1'b0;
			if (state == uart_frame_pkg::TX_IDLE) begin
				if (cmd.start && cmd.length != '0) begin
					state <= uart_frame_pkg::TX_OPEN1;
					len_q <= cmd.length;
					idx   <= '0;
					kick  <= 1'b1;
				end
			end else begin
				state <= nxt_state;
				idx   <= nxt_idx;
			end
		end
	end

	// own copy, so the host can refill its buffer during a frame
	always_ff @(posedge sys_clk) begin
		if (state == uart_frame_pkg::TX_IDLE && cmd.start)
			payload_q <= payload;
	end

endmodule

// File: hw/uart_byte_rx.sv
`timescale 1ns/1ps
/*
 * 8N1 deserializer
 * two-flop input sync, start bit re-check, mid-bit sampling
 */
module uart_byte_rx (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      rxd,
	output uart_frame_pkg::byte_req_t rx_byte
);

	uart_frame_pkg::bit_state_e state;
	logic [uart_frame_pkg::BIT_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic rxd_s1;
	logic rxd_s2;
	logic rxd_d;
	logic fall;

	assign fall = rxd_d & ~rxd_s2;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_d  <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_d  <= rxd_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= uart_frame_pkg::BIT_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			shift_q <= '0;
			rx_byte <= '0;
		end else begin
			rx_byte.valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				uart_frame_pkg::BIT_IDLE: begin
					clk_cnt <= '0;
					if (fall)
						state <= uart_frame_pkg::BIT_START;
				end
				uart_frame_pkg::BIT_START: begin
					// half a bit in, a glitch has gone high again
					if (clk_cnt == uart_frame_pkg::BIT_HALF) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rxd_s2 ? uart_frame_pkg::BIT_IDLE : uart_frame_pkg::BIT_DATA;
					end
				end
				uart_frame_pkg::BIT_DATA: begin
					if (clk_cnt == uart_frame_pkg::BIT_LAST) begin
						clk_cnt <= '0;
						shift_q <= {rxd_s2, shift_q[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_frame_pkg::BIT_STOP;
					end
				end
				default: begin
					// mid stop bit, framing error drops the byte
					if (clk_cnt == uart_frame_pkg::BIT_LAST) begin
						state         <= uart_frame_pkg::BIT_IDLE;
						rx_byte.valid <= rxd_s2;
						rx_byte.data  <= shift_q;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/uart_byte_tx.sv
`timescale 1ns/1ps
/*
 * 8N1 serializer, one byte per request, LSB first
 */
module uart_byte_tx (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  uart_frame_pkg::byte_req_t req,
	output logic                      txd,
	output logic                      done
);

	uart_frame_pkg::bit_state_e state;
	logic [uart_frame_pkg::BIT_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic bit_end;

	assign bit_end = (clk_cnt == uart_frame_pkg::BIT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= uart_frame_pkg::BIT_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			shift_q <= '0;
			txd     <= 1'b1;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			// bit timer only runs while a byte is on the line
			if (state == uart_frame_pkg::BIT_IDLE || bit_end)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;
			case (state)
				uart_frame_pkg::BIT_IDLE: begin
					if (req.valid) begin
						state   <= uart_frame_pkg::BIT_START;
						txd     <= 1'b0;
						shift_q <= req.data;
					end
				end
				uart_frame_pkg::BIT_START: begin
					if (bit_end) begin
						state   <= uart_frame_pkg::BIT_DATA;
						txd     <= shift_q[0];
						shift_q <= shift_q >> 1;
						bit_idx <= '0;
					end
				end
				uart_frame_pkg::BIT_DATA: begin
					if (bit_end && bit_idx == 3'd7) begin
						state <= uart_frame_pkg::BIT_STOP;
						txd   <= 1'b1;
					end else if (bit_end) begin
						txd     <= shift_q[0];
						shift_q <= shift_q >> 1;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: begin
					// stop bit, done lands one cycle after it ends
					if (bit_end) begin
						state <= uart_frame_pkg::BIT_IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/uart_frame_pkg.sv
/*
 * framing constants and counter limits of the uart frame link
 * payload, byte, command, write and result structs
 * state enums of the frame engines and the byte modules
 */
package uart_frame_pkg;

	localparam int MAX_LEN = 16;
	localparam int LEN_W = 5;
	localparam int CLKS_PER_BIT = 16;
	localparam int RX_TIMEOUT_CLKS = 400;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int TMO_CNT_W = $clog2(RX_TIMEOUT_CLKS);

	// '{' and '}'
	localparam logic [7:0] OPEN_CHAR = 8'h7b;
	localparam logic [7:0] CLOSE_CHAR = 8'h7d;

	// end values sized to their counters
	localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_LEN);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] BIT_HALF = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [TMO_CNT_W-1:0] TMO_LAST = TMO_CNT_W'(RX_TIMEOUT_CLKS - 1);

	// byte 0 goes on the line first
	typedef logic [MAX_LEN-1:0][7:0] payload_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_req_t;

	typedef struct packed {
		logic             start;
		logic [LEN_W-1:0] length;
	} tx_cmd_t;

	typedef struct packed {
		logic       en;
		logic [3:0] idx;
		logic [7:0] data;
	} rx_wr_t;

	typedef struct packed {
		logic             done;
		logic [LEN_W-1:0] length;
		logic             overflow;
	} rx_result_t;

	typedef enum logic [2:0] {
		TX_IDLE, TX_OPEN1, TX_OPEN2, TX_BODY, TX_CLOSE1, TX_CLOSE2
	} tx_state_e;

	typedef enum logic [1:0] {RX_IDLE, RX_OPEN1, RX_BODY, RX_CLOSE1} rx_state_e;

	typedef enum logic [1:0] {BIT_IDLE, BIT_START, BIT_DATA, BIT_STOP} bit_state_e;

endpackage

// File: hw/uart_frame_top.sv
`timescale 1ns/1ps
/*
 * top level of the framed uart link
 * register slave, frame engines and byte serdes
 */
module uart_frame_top (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	input  logic                uart_rx,
	output logic                uart_tx
);

	uart_frame_pkg::tx_cmd_t tx_cmd;
	uart_frame_pkg::payload_t tx_payload;
	uart_frame_pkg::byte_req_t tx_byte;
	uart_frame_pkg::byte_req_t rx_byte;
	uart_frame_pkg::rx_wr_t rx_wr;
	uart_frame_pkg::rx_result_t rx_result;
	logic tx_busy;
	logic tx_byte_done;

	frame_ctrl_regs u_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.tx_busy    (tx_busy),
		.tx_cmd     (tx_cmd),
		.tx_payload (tx_payload),
		.rx_wr      (rx_wr),
		.rx_result  (rx_result)
	);

	frame_tx_engine u_tx_engine (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd       (tx_cmd),
		.payload   (tx_payload),
		.byte_done (tx_byte_done),
		.byte_req  (tx_byte),
		.busy      (tx_busy)
	);

	uart_byte_tx u_byte_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (tx_byte),
		.txd       (uart_tx),
		.done      (tx_byte_done)
	);

	uart_byte_rx u_byte_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx),
		.rx_byte   (rx_byte)
	);

	frame_rx_engine u_rx_engine (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.wr        (rx_wr),
		.result    (rx_result)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the frame link testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module tb_uart_frame -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

// File: testbench/tb_uart_frame.sv
`timescale 1ns/1ps
/*
 * testbench of the framed uart link
 * AXI4-Lite host tasks, serial line driver, stimulus table and checks
 */
module tb_uart_frame;

	localparam int N_ENT = 6;
	localparam int SEQ_MAX = 24;
	localparam int POLL_MAX = 4000;
	localparam int BIT_CLKS = uart_frame_pkg::CLKS_PER_BIT;

	logic sys_clk;
	logic sys_rst_n;
	axil_pkg::axil_req_t axil_req;
	axil_pkg::axil_rsp_t axil_rsp;
	logic uart_rx;
	logic uart_tx;
	logic loopback;
	logic ser_line;

	// stimulus table, one entry per frame test
	string      t_name [N_ENT];
	logic       t_loop [N_ENT];
	logic [7:0] t_seq [N_ENT][SEQ_MAX];
	int         t_seq_len [N_ENT];
	int         t_gap_at [N_ENT];
	int         t_exp_len [N_ENT];
	logic [7:0] t_exp [N_ENT][uart_frame_pkg::MAX_LEN];
	logic       t_exp_ovf [N_ENT];

	string cur_name;
	int test_errs;
	int err_total;
	int n_pass;
	int n_fail;

	// receive line is either our own transmitter or the serial driver
	assign uart_rx = loopback ? uart_tx : ser_line;

	uart_frame_top UUT (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx)
	);

	always #50 sys_clk = ~sys_clk;

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, exp, act);
		test_errs++;
	endtask

	task automatic report_problem(input string msg);
		$display("error in %s: %s", cur_name, msg);
		test_errs++;
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		bit seen;
		seen = 1'b0;
		@(negedge sys_clk);
		axil_req.awaddr = addr;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b1;
		// bvalid seen means the write went through on the edge before
		for (int i = 0; i < 20 && !seen; i++) begin
			@(negedge sys_clk);
			if (axil_rsp.bvalid)
				seen = 1'b1;
		end
		// address and data still offered while the response is pending
		if (seen && (axil_rsp.awready || axil_rsp.wready))
			report_mismatch("awready and wready with B pending", 32'h0,
				32'({axil_rsp.awready, axil_rsp.wready}));
		if (seen && axil_rsp.bresp != 2'b00)
			report_mismatch("bresp", 32'h0, 32'(axil_rsp.bresp));
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		@(negedge sys_clk);
		axil_req.bready = 1'b0;
		if (!seen)
			report_problem($sformatf("no write response for address 0x%02h", addr));
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
		bit seen;
		seen = 1'b0;
		data = '0;
		@(negedge sys_clk);
		if (axil_rsp.arready !== 1'b1)
			report_mismatch("arready with no read pending", 32'h1, 32'(axil_rsp.arready));
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b0;
		for (int i = 0; i < 20 && !seen; i++) begin
			@(negedge sys_clk);
			if (axil_rsp.rvalid) begin
				seen = 1'b1;
				data = axil_rsp.rdata;
			end
		end
		if (seen && axil_rsp.arready)
			report_mismatch("arready with R pending", 32'h0, 32'(axil_rsp.arready));
		if (seen && axil_rsp.rresp != 2'b00)
			report_mismatch("rresp", 32'h0, 32'(axil_rsp.rresp));
		axil_req.arvalid = 1'b0;
		axil_req.rready = 1'b1;
		@(negedge sys_clk);
		axil_req.rready = 1'b0;
		if (!seen)
			report_problem($sformatf("no read data for address 0x%02h", addr));
	endtask

	// 8N1, LSB first, two idle cycles after the stop bit
	task automatic send_serial(input logic [7:0] b);
		@(negedge sys_clk);
		ser_line = 1'b0;
		repeat (BIT_CLKS) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			ser_line = b[i];
			repeat (BIT_CLKS) @(negedge sys_clk);
		end
		ser_line = 1'b1;
		repeat (BIT_CLKS + 2) @(negedge sys_clk);
	endtask

	task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
		output logic [31:0] st, output bit ok);
		ok = 1'b0;
		st = '0;
		for (int i = 0; i < POLL_MAX && !ok; i++) begin
			axil_read(axil_pkg::STATUS, st);
			if ((st & mask) == want)
				ok = 1'b1;
		end
	endtask

	task automatic clear_status();
		axil_write(axil_pkg::STATUS, 32'h2, 4'h1);
	endtask

	task automatic set_seq(input int i, input string s);
		t_seq_len[i] = s.len();
		for (int k = 0; k < s.len(); k++)
			t_seq[i][k] = s[k];
	endtask

	task automatic set_exp(input int i, input string s);
		t_exp_len[i] = s.len();
		for (int k = 0; k < s.len(); k++)
			t_exp[i][k] = s[k];
	endtask

	// random payload without a close brace, sent as is
	task automatic fill_random(input int i, input int n);
		logic [7:0] b;
		for (int k = 0; k < n; k++) begin
			do
				b = 8'($urandom());
			while (b == uart_frame_pkg::CLOSE_CHAR);
			t_seq[i][k] = b;
			t_exp[i][k] = b;
		end
		t_seq_len[i] = n;
		t_exp_len[i] = n;
	endtask

	task automatic build_table();
		for (int i = 0; i < N_ENT; i++) begin
			t_loop[i] = 1'b0;
			t_seq_len[i] = 0;
			t_gap_at[i] = -1;
			t_exp_len[i] = 0;
			t_exp_ovf[i] = 1'b0;
			for (int k = 0; k < SEQ_MAX; k++)
				t_seq[i][k] = 8'h00;
			for (int k = 0; k < uart_frame_pkg::MAX_LEN; k++)
				t_exp[i][k] = 8'h00;
		end
		t_name[0] = "loopback length 1";
		t_loop[0] = 1'b1;
		fill_random(0, 1);
		t_name[1] = "loopback length 5 with lone brace";
		t_loop[1] = 1'b1;
		set_seq(1, "q}Axy");
		set_exp(1, "q}Axy");
		t_name[2] = "loopback length 16";
		t_loop[2] = 1'b1;
		fill_random(2, 16);
		t_name[3] = "serial bytes around a frame";
		set_seq(3, "xy{{ab}}");
		set_exp(3, "ab");
		// silence after the b of the first, unfinished frame
		t_name[4] = "serial silence timeout";
		set_seq(4, "{{ab{{c}}");
		t_gap_at[4] = 3;
		set_exp(4, "c");
		t_name[5] = "serial overflow of 18 bytes";
		set_seq(5, "{{ABCDEFGHIJKLMNOPQR}}");
		set_exp(5, "ABCDEFGHIJKLMNOP");
		t_exp_ovf[5] = 1'b1;
	endtask

	task automatic check_reset_state();
		logic [31:0] st;
		int low_cnt;
		if ({axil_rsp.bvalid, axil_rsp.rvalid} != 2'b00)
			report_mismatch("bvalid and rvalid after reset", 32'h0,
				32'({axil_rsp.bvalid, axil_rsp.rvalid}));
		axil_read(axil_pkg::STATUS, st);
		if (st != 32'h0)
			report_mismatch("STATUS after reset", 32'h0, st);
		axil_write(axil_pkg::CTRL, 32'h100, 4'h3);
		low_cnt = 0;
		repeat (4 * BIT_CLKS) begin
			@(negedge sys_clk);
			if (uart_tx !== 1'b1)
				low_cnt++;
		end
		if (low_cnt != 0)
			report_mismatch("uart_tx low cycles", 32'h0, 32'(low_cnt));
		axil_read(axil_pkg::STATUS, st);
		if (st[0] != 1'b0)
			report_mismatch("tx_busy after zero length start", 32'h0, 32'(st[0]));
	endtask

	task automatic run_entry(input int i);
		logic [31:0] st;
		logic [31:0] word;
		bit ok;
		if (t_loop[i]) begin
			loopback = 1'b1;
			for (int w = 0; w < 4; w++) begin
				word = {t_seq[i][4*w+3], t_seq[i][4*w+2], t_seq[i][4*w+1], t_seq[i][4*w]};
				axil_write(8'(axil_pkg::TX_BUF0) + 8'(4 * w), word, 4'hf);
			end
			axil_write(axil_pkg::CTRL, 32'h100 | 32'(t_exp_len[i]), 4'h3);
		end else begin
			loopback = 1'b0;
			for (int k = 0; k < t_seq_len[i]; k++) begin
				send_serial(t_seq[i][k]);
				if (k == t_gap_at[i])
					repeat (uart_frame_pkg::RX_TIMEOUT_CLKS + 100) @(negedge sys_clk);
			end
		end
		wait_status(32'h2, 32'h2, st, ok);
		if (!ok)
			report_problem("rx_valid never set");
		wait_status(32'h1, 32'h0, st, ok);
		if (!ok)
			report_problem("tx_busy never fell");
		if (32'(st[12:8]) != 32'(t_exp_len[i]))
			report_mismatch("rx_length", 32'(t_exp_len[i]), 32'(st[12:8]));
		if (st[2] != t_exp_ovf[i])
			report_mismatch("overflow", 32'(t_exp_ovf[i]), 32'(st[2]));
		for (int w = 0; w < 4; w++) begin
			axil_read(8'(axil_pkg::RX_BUF0) + 8'(4 * w), word);
			for (int b = 0; b < 4; b++) begin
				if (4 * w + b < t_exp_len[i] && word[8*b +: 8] != t_exp[i][4*w+b])
					report_mismatch($sformatf("rx byte %0d", 4 * w + b),
						32'(t_exp[i][4*w+b]), 32'(word[8*b +: 8]));
			end
		end
		clear_status();
		axil_read(axil_pkg::STATUS, st);
		if (st[2:1] != 2'b00)
			report_mismatch("rx_valid and overflow after clear", 32'h0, 32'(st[2:1]));
	endtask

	task automatic check_busy_start();
		logic [31:0] st;
		logic [31:0] word;
		bit ok;
		int low_cnt;
		loopback = 1'b1;
		// payload abcd efgh ijkl mnop
		for (int w = 0; w < 4; w++) begin
			word = 32'h64636261 + 32'h04040404 * w;
			axil_write(8'(axil_pkg::TX_BUF0) + 8'(4 * w), word, 4'hf);
		end
		axil_write(axil_pkg::CTRL, 32'h103, 4'h3);
		axil_read(axil_pkg::STATUS, st);
		if (st[0] != 1'b1)
			report_mismatch("tx_busy after start", 32'h1, 32'(st[0]));
		axil_write(axil_pkg::CTRL, 32'h107, 4'h3);
		wait_status(32'h2, 32'h2, st, ok);
		if (!ok)
			report_problem("rx_valid never set");
		wait_status(32'h1, 32'h0, st, ok);
		if (!ok)
			report_problem("tx_busy never fell");
		if (st[12:8] != 5'd3)
			report_mismatch("rx_length", 32'h3, 32'(st[12:8]));
		axil_read(axil_pkg::RX_BUF0, word);
		if (word[23:0] != 24'h636261)
			report_mismatch("rx payload", 32'h636261, 32'(word[23:0]));
		clear_status();
		// a second frame of 7 bytes would pull the line low and set rx_valid again
		low_cnt = 0;
		repeat ((7 + 4) * 11 * BIT_CLKS) begin
			@(negedge sys_clk);
			if (uart_tx !== 1'b1)
				low_cnt++;
		end
		if (low_cnt != 0)
			report_mismatch("uart_tx low cycles after the frame", 32'h0, 32'(low_cnt));
		axil_read(axil_pkg::STATUS, st);
		if (st[1] != 1'b0)
			report_mismatch("rx_valid after the frame", 32'h0, 32'(st[1]));
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("[PASS] %s", cur_name);
			n_pass++;
		end else begin
			$display("failed: %s with %0d error(s)", cur_name, test_errs);
			n_fail++;
		end
		err_total += test_errs;
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		axil_req = '0;
		loopback = 1'b0;
		ser_line = 1'b1;
		cur_name = "";
		test_errs = 0;
		err_total = 0;
		n_pass = 0;
		n_fail = 0;
		void'($urandom(32'hd5ab6c3d));
		build_table();
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		begin_test("reset state and zero length start");
		check_reset_state();
		end_test();
		for (int i = 0; i < N_ENT; i++) begin
			begin_test(t_name[i]);
			run_entry(i);
			end_test();
		end
		begin_test("start while busy");
		check_busy_start();
		end_test();
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			n_pass + n_fail, n_pass, n_fail, err_total);
		if (n_fail == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
